/* Bender.yml */
package:
  name: eth_rx

sources:
  - source/eth_rx_pkg.sv
  - source/rmii_frame_rx.sv
  - source/dibit_reorder.sv
  - source/mac_filter.sv
  - source/word_aggregator.sv
  - source/fcs_checker.sv
  - source/eth_rx_top.sv
  - target: test
    files:
      - tests/tb_eth_rx.sv

/* all.f */
source/eth_rx_pkg.sv
source/rmii_frame_rx.sv
source/dibit_reorder.sv
source/mac_filter.sv
source/word_aggregator.sv
source/fcs_checker.sv
source/eth_rx_top.sv
tests/tb_eth_rx.sv

/* source/dibit_reorder.sv */
`timescale 1ns/1ps

module dibit_reorder (
  input  logic                  clk_50mhz,
  input  logic                  sys_rst,
  input  eth_rx_pkg::rx_dibit_t frame_dibits,
  output eth_rx_pkg::rx_dibit_t ordered_dibits
);

  localparam int LAST_SLOT = eth_rx_pkg::DIBITS_PER_BYTE - 1;

  // first three dibits of the byte being filled
  logic [LAST_SLOT-1:0][1:0]                    fill_buf;
  // complete byte being replayed with the wire-first dibit at index 0
  logic [eth_rx_pkg::DIBITS_PER_BYTE-1:0][1:0] byte_buf;
  logic [1:0] slot;
  logic [1:0] replay;
  logic       buf_full;
  logic       byte_done;

  assign byte_done = frame_dibits.valid && (slot == 2'(LAST_SLOT));

  always_ff @(posedge clk_50mhz) begin
    if (sys_rst) begin
      slot     <= '0;
      replay   <= '0;
      buf_full <= 1'b0;
    end else begin
      // partial byte at frame end is dropped here
      slot <= frame_dibits.valid ? slot + 1'b1 : '0;
      if (byte_done) begin
        replay   <= 2'(LAST_SLOT);
        buf_full <= 1'b1;
      end else if (buf_full) begin
        if (replay == '0) begin
          buf_full <= 1'b0;
        end else begin
          replay <= replay - 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_50mhz) begin
    if (frame_dibits.valid && !byte_done) begin
      fill_buf[slot] <= frame_dibits.data;
    end
    if (byte_done) begin
      byte_buf <= {frame_dibits.data, fill_buf};
    end
  end

  // most significant dibit goes out first
  assign ordered_dibits = '{valid: buf_full, data: byte_buf[replay]};

  // a new byte only reloads the replay counter once the previous byte is on its last beat
  assert property (@(posedge clk_50mhz) disable iff (sys_rst)
    byte_done |-> (!buf_full || replay == 2'd0));

endmodule

/* source/eth_rx_pkg.sv */
package eth_rx_pkg;

  // one RMII beat on the receive stream
  typedef struct packed {
    logic       valid;
    logic [1:0] data;
  } rx_dibit_t;

  // station address, first wire byte in the top byte
  typedef logic [47:0] mac_addr_t;

  // stream geometry
  localparam int DIBITS_PER_BYTE = 4;

  // idle pattern of the preamble and last dibit of the delimiter
  localparam logic [1:0] PREAMBLE_DIBIT = 2'b01;
  localparam logic [1:0] SFD_DIBIT      = 2'b11;

  // 14 header bytes
  localparam int HEADER_DIBITS = 56;

  // 6-byte destination address
  localparam int DEST_DIBITS = 24;

  // 32-bit payload word
  localparam int WORD_DIBITS = 16;

  // reflected IEEE 802.3 polynomial
  localparam logic [31:0] CRC_POLY = 32'hEDB88320;

  // register value after a frame with a correct FCS has been shifted in
  localparam logic [31:0] CRC_RESIDUE = 32'hDEBB20E3;

  localparam mac_addr_t BROADCAST_MAC = 48'hFFFF_FFFF_FFFF;

  // good-frame counter
  localparam int COUNT_WIDTH = 14;

endpackage

/* source/eth_rx_top.sv */
`timescale 1ns/1ps

module eth_rx_top #(
  parameter eth_rx_pkg::mac_addr_t station_mac = 48'h02_00_00_C0_FF_EE
) (
  input  logic                               clk_50mhz,
  input  logic                               sys_rst,
  input  logic                               crsdv,
  input  logic [1:0]                         rxd,
  output logic [31:0]                        payload_word,
  output logic                               word_valid,
  output logic                               accept,
  output logic                               frame_done,
  output logic                               frame_ok,
  output logic [eth_rx_pkg::COUNT_WIDTH-1:0] good_count
);

  eth_rx_pkg::rx_dibit_t frame_dibits;
  eth_rx_pkg::rx_dibit_t ordered_dibits;
  eth_rx_pkg::rx_dibit_t payload_dibits;

  rmii_frame_rx i_rmii_frame_rx (
    .clk_50mhz    (clk_50mhz),
    .sys_rst      (sys_rst),
    .crsdv        (crsdv),
    .rxd          (rxd),
    .frame_dibits (frame_dibits)
  );

  dibit_reorder i_dibit_reorder (
    .clk_50mhz      (clk_50mhz),
    .sys_rst        (sys_rst),
    .frame_dibits   (frame_dibits),
    .ordered_dibits (ordered_dibits)
  );

  mac_filter #(
    .station_mac (station_mac)
  ) i_mac_filter (
    .clk_50mhz      (clk_50mhz),
    .sys_rst        (sys_rst),
    .ordered_dibits (ordered_dibits),
    .payload_dibits (payload_dibits),
    .accept         (accept)
  );

  word_aggregator i_word_aggregator (
    .clk_50mhz      (clk_50mhz),
    .sys_rst        (sys_rst),
    .payload_dibits (payload_dibits),
    .payload_word   (payload_word),
    .word_valid     (word_valid)
  );

  // CRC runs on the wire-order stream
  fcs_checker i_fcs_checker (
    .clk_50mhz    (clk_50mhz),
    .sys_rst      (sys_rst),
    .frame_dibits (frame_dibits),
    .frame_done   (frame_done),
    .frame_ok     (frame_ok)
  );

  // accept still holds the decision of the frame that just ended
  always_ff @(posedge clk_50mhz) begin
    if (sys_rst) begin
      good_count <= '0;
    end else if (frame_done && frame_ok && accept) begin
      good_count <= good_count + 1'b1;
    end
  end

endmodule

/* source/fcs_checker.sv */
`timescale 1ns/1ps

module fcs_checker (
  input  logic                  clk_50mhz,
  input  logic                  sys_rst,
  input  eth_rx_pkg::rx_dibit_t frame_dibits,
  output logic                  frame_done,
  output logic                  frame_ok
);

  logic [31:0] crc_reg;
  logic [31:0] crc_seed;
  logic        in_frame;
  logic        frame_end;

  // two bits per beat, bit 0 is first on the wire
  function automatic logic [31:0] crc_step(input logic [31:0] crc, input logic [1:0] dibit);
    logic [31:0] c;
    c = crc;
    for (int i = 0; i < 2; i++) begin
      if (c[0] ^ dibit[i]) begin
        c = (c >> 1) ^ eth_rx_pkg::CRC_POLY;
      end else begin
        c = c >> 1;
      end
    end
    return c;
  endfunction

  // each frame starts from all ones
  assign crc_seed  = in_frame ? crc_reg : '1;
  assign frame_end = in_frame && !frame_dibits.valid;

  always_ff @(posedge clk_50mhz) begin
    if (frame_dibits.valid) begin
      crc_reg <= crc_step(crc_seed, frame_dibits.data);
    end
  end

  always_ff @(posedge clk_50mhz) begin
    if (sys_rst) begin
      in_frame   <= 1'b0;
      frame_done <= 1'b0;
      frame_ok   <= 1'b0;
    end else begin
      in_frame   <= frame_dibits.valid;
      frame_done <= frame_end;
      if (frame_end) begin
        // FCS included, so a clean frame leaves the fixed residue
        frame_ok <= (crc_reg == eth_rx_pkg::CRC_RESIDUE);
      end
    end
  end

  // one result pulse per frame
  assert property (@(posedge clk_50mhz) disable iff (sys_rst)
    frame_done |=> !frame_done);

endmodule

/* source/mac_filter.sv */
`timescale 1ns/1ps

module mac_filter #(
  parameter eth_rx_pkg::mac_addr_t station_mac = 48'h0
) (
  input  logic                  clk_50mhz,
  input  logic                  sys_rst,
  input  eth_rx_pkg::rx_dibit_t ordered_dibits,
  output eth_rx_pkg::rx_dibit_t payload_dibits,
  output logic                  accept
);

  localparam int CNT_W = $clog2(eth_rx_pkg::HEADER_DIBITS + 1);

  // counter saturates at the header length
  logic [CNT_W-1:0]      beat_cnt;
  logic                  first_beat;
  logic                  last_dest;
  logic                  in_dest;
  eth_rx_pkg::mac_addr_t st_shifted;
  eth_rx_pkg::mac_addr_t bc_shifted;
  logic                  st_match;
  logic                  bc_match;
  logic                  st_next;
  logic                  bc_next;
  logic                  pay_valid;
  logic [1:0]            pay_data;

  assign first_beat = (beat_cnt == '0);
  assign last_dest  = (beat_cnt == CNT_W'(eth_rx_pkg::DEST_DIBITS - 1));
  assign in_dest    = (beat_cnt < CNT_W'(eth_rx_pkg::DEST_DIBITS));

  // address dibits arrive most significant first
  assign st_shifted = station_mac << {beat_cnt, 1'b0};
  assign bc_shifted = eth_rx_pkg::BROADCAST_MAC << {beat_cnt, 1'b0};

  assign st_next = (first_beat || st_match) && (ordered_dibits.data == st_shifted[47:46]);
  assign bc_next = (first_beat || bc_match) && (ordered_dibits.data == bc_shifted[47:46]);

  always_ff @(posedge clk_50mhz) begin
    if (sys_rst) begin
      beat_cnt  <= '0;
      st_match  <= 1'b0;
      bc_match  <= 1'b0;
      accept    <= 1'b0;
      pay_valid <= 1'b0;
    end else begin
      pay_valid <= ordered_dibits.valid && accept &&
                   (beat_cnt == CNT_W'(eth_rx_pkg::HEADER_DIBITS));
      if (!ordered_dibits.valid) begin
        beat_cnt <= '0;
      end else begin
        if (beat_cnt != CNT_W'(eth_rx_pkg::HEADER_DIBITS)) begin
          beat_cnt <= beat_cnt + 1'b1;
        end
        if (in_dest) begin
          st_match <= st_next;
          bc_match <= bc_next;
        end
        // decision holds until the next frame begins
        if (last_dest) begin
          accept <= st_next || bc_next;
        end else if (first_beat) begin
          accept <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk_50mhz) begin
    pay_data <= ordered_dibits.data;
  end

  assign payload_dibits = '{valid: pay_valid, data: pay_data};

  // only accepted frames reach the payload stream
  assert property (@(posedge clk_50mhz) disable iff (sys_rst)
    payload_dibits.valid |-> accept);

endmodule

/* source/rmii_frame_rx.sv */
`timescale 1ns/1ps

module rmii_frame_rx (
  input  logic                  clk_50mhz,
  input  logic                  sys_rst,
  input  logic                  crsdv,
  input  logic [1:0]            rxd,
  output eth_rx_pkg::rx_dibit_t frame_dibits
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_PREAMBLE,
    ST_DATA
  } state_t;

  state_t     state;
  logic       sfd_hit;
  logic       out_valid;
  logic [1:0] out_data;

  // delimiter closes the preamble
  assign sfd_hit = (state == ST_PREAMBLE) && crsdv && (rxd == eth_rx_pkg::SFD_DIBIT);

  always_ff @(posedge clk_50mhz) begin
    if (sys_rst) begin
      state     <= ST_IDLE;
      out_valid <= 1'b0;
    end else begin
      out_valid <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (crsdv && rxd == eth_rx_pkg::PREAMBLE_DIBIT) begin
            state <= ST_PREAMBLE;
          end
        end
        ST_PREAMBLE: begin
          if (!crsdv) begin
            state <= ST_IDLE;
          end else if (sfd_hit) begin
            state <= ST_DATA;
          end else if (rxd != eth_rx_pkg::PREAMBLE_DIBIT) begin
            // broken preamble, frame is rejected
            state <= ST_IDLE;
          end
        end
        ST_DATA: begin
          if (crsdv) begin
            out_valid <= 1'b1;
          end else begin
            state <= ST_IDLE;
          end
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  // data dibit follows the input by one cycle
  always_ff @(posedge clk_50mhz) begin
    out_data <= rxd;
  end

  assign frame_dibits = '{valid: out_valid, data: out_data};

  // first beat of a frame needs the delimiter one input cycle before it
  assert property (@(posedge clk_50mhz) disable iff (sys_rst)
    $rose(frame_dibits.valid) |-> $past(sfd_hit, 2));

endmodule

/* source/word_aggregator.sv */
`timescale 1ns/1ps

module word_aggregator (
  input  logic                  clk_50mhz,
  input  logic                  sys_rst,
  input  eth_rx_pkg::rx_dibit_t payload_dibits,
  output logic [31:0]           payload_word,
  output logic                  word_valid
);

  localparam int CNT_W   = $clog2(eth_rx_pkg::WORD_DIBITS + 1);
  localparam int SHIFT_W = 2 * (eth_rx_pkg::WORD_DIBITS - 1);

  logic [CNT_W-1:0]   beat_cnt;
  logic [SHIFT_W-1:0] shift_reg;
  logic               shift_en;
  logic               word_done;

  // stop collecting once the word is full
  assign shift_en  = payload_dibits.valid && (beat_cnt != CNT_W'(eth_rx_pkg::WORD_DIBITS));
  assign word_done = shift_en && (beat_cnt == CNT_W'(eth_rx_pkg::WORD_DIBITS - 1));

  always_ff @(posedge clk_50mhz) begin
    if (sys_rst) begin
      beat_cnt   <= '0;
      word_valid <= 1'b0;
    end else begin
      word_valid <= word_done;
      if (!payload_dibits.valid) begin
        beat_cnt <= '0;
      end else if (shift_en) begin
        beat_cnt <= beat_cnt + 1'b1;
      end
    end
  end

  // first payload dibit ends up in the top bits
  always_ff @(posedge clk_50mhz) begin
    if (shift_en) begin
      shift_reg <= {shift_reg[SHIFT_W-3:0], payload_dibits.data};
    end
    if (word_done) begin
      payload_word <= {shift_reg, payload_dibits.data};
    end
  end

endmodule

/* tests/eth_rx_vectors.hex */
// header row: id, length in bytes, accept, frame_ok, payload word (first payload byte first)
// then 64 frame bytes in two rows: preamble, SFD, header, payload, FCS, zero padding
01 1e 01 01 96 30 07 77
55 55 55 55 55 55 55 d5 ff ff ff ff ff ff ff 12 26 be 00 00 00 01 96 30 07 77 ff ff ff ff 00 00
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
02 1e 01 01 32 88 db 0e
55 55 55 55 55 55 55 d5 02 00 00 c0 ff ee 1a 5b cc 46 00 00 00 08 32 88 db 0e ff ff ff ff 00 00
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
03 1e 00 01 00 00 00 00
55 55 55 55 55 55 55 d5 ff ff ff ff 00 00 00 00 00 00 00 00 00 04 19 c4 6d 07 ff ff ff ff 00 00
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
04 1e 01 00 2c 61 0e ee
55 55 55 55 55 55 55 d5 02 00 00 c0 ff ee 1a 5b cc 46 00 00 00 02 2c 61 0e ee ff ff 7f ff 00 00
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
05 24 01 01 20 83 b8 ed
55 55 55 55 55 55 55 d5 ff ff ff ff ff ff ff 12 26 be 00 00 00 80 20 83 b8 ed 00 00 00 00 00 00
ff ff ff ff 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
06 20 01 01 64 10 b7 1d
55 55 55 55 55 55 55 d5 02 00 00 c0 ff ee 1a 5b cc 46 00 00 00 10 64 10 b7 1d 00 00 ff ff ff ff
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00

/* tests/tb_eth_rx.sv */
`timescale 1ns/1ps

module tb_eth_rx;

  localparam int NUM_REC     = 6;
  localparam int REC_BYTES   = 72;
  localparam int FRAME_SLOTS = 64;
  localparam int CYCLE_LIMIT = NUM_REC * (FRAME_SLOTS * 4 + 20) + 200;

  logic                               clk_50mhz;
  logic                               sys_rst;
  logic                               crsdv;
  logic [1:0]                         rxd;
  logic [31:0]                        payload_word;
  logic                               word_valid;
  logic                               accept;
  logic                               frame_done;
  logic                               frame_ok;
  logic [eth_rx_pkg::COUNT_WIDTH-1:0] good_count;

  logic [7:0]  vec_mem [0:NUM_REC*REC_BYTES-1];
  integer      seed;
  int          errors = 0;
  int          passed = 0;
  int          cycles = 0;
  int          exp_good = 0;
  int          words_seen;
  int          dones_seen;
  logic [31:0] word_got;
  logic        ok_got;
  logic        accept_got;

  eth_rx_top i_eth_rx_top (
    .clk_50mhz    (clk_50mhz),
    .sys_rst      (sys_rst),
    .crsdv        (crsdv),
    .rxd          (rxd),
    .payload_word (payload_word),
    .word_valid   (word_valid),
    .accept       (accept),
    .frame_done   (frame_done),
    .frame_ok     (frame_ok),
    .good_count   (good_count)
  );

  initial begin
    clk_50mhz = 1'b0;
    forever #10 clk_50mhz = ~clk_50mhz;
  end

  // outputs are sampled mid-cycle
  always @(negedge clk_50mhz) begin
    if (word_valid) begin
      words_seen = words_seen + 1;
      word_got   = payload_word;
    end
    if (frame_done) begin
      dones_seen = dones_seen + 1;
      ok_got     = frame_ok;
      accept_got = accept;
    end
  end

  always @(posedge clk_50mhz) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout: the run did not finish within %0d clock cycles", CYCLE_LIMIT);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  task automatic report_mismatch(input string what, input int id, input logic [31:0] got,
                                 input logic [31:0] want);
    $display("ERROR at %0t: frame %0d %s is %0h, expected %0h", $time, id, what, got, want);
    errors++;
  endtask

  task automatic report_test(input int num, input int errs_before);
    if (errors == errs_before) begin
      passed++;
      $display("test %0d: ok", num);
    end else begin
      $display("test %0d: failed with %0d errors", num, errors - errs_before);
    end
  endtask

  // bytes go out as four dibits each, least significant first
  task automatic send_frame(input int base, output int idle);
    int         len;
    logic [7:0] cur;
    len = vec_mem[base+1];
    words_seen = 0;
    dones_seen = 0;
    for (int i = 0; i < len; i++) begin
      cur = vec_mem[base+8+i];
      for (int k = 0; k < 4; k++) begin
        @(posedge clk_50mhz);
        #2;
        crsdv = 1'b1;
        rxd   = cur[2*k +: 2];
      end
    end
    @(posedge clk_50mhz);
    #2;
    crsdv = 1'b0;
    rxd   = 2'b00;
    idle  = 0;
    while (dones_seen == 0 && idle < 8) begin
      @(posedge clk_50mhz);
      idle++;
    end
    // let the counter settle after the result pulse
    @(posedge clk_50mhz);
    #5;
    idle++;
  endtask

  task automatic check_frame(input int base);
    int          id;
    logic        exp_acc;
    logic        exp_ok;
    logic [31:0] exp_word;
    id       = vec_mem[base];
    exp_acc  = (vec_mem[base+2] != 8'h00);
    exp_ok   = (vec_mem[base+3] != 8'h00);
    exp_word = {vec_mem[base+4], vec_mem[base+5], vec_mem[base+6], vec_mem[base+7]};
    if (exp_acc && exp_ok) begin
      exp_good++;
    end
    if (dones_seen == 0) begin
      $display("frame %0d: frame_done did not arrive within 8 cycles of the carrier drop", id);
      errors++;
    end else begin
      assert (dones_seen == 1) else report_mismatch("frame_done count", id, dones_seen, 1);
      assert (accept_got == exp_acc) else report_mismatch("accept", id, accept_got, exp_acc);
      assert (ok_got == exp_ok) else report_mismatch("frame_ok", id, ok_got, exp_ok);
    end
    assert (words_seen == int'(exp_acc)) else
      report_mismatch("word_valid count", id, words_seen, exp_acc);
    if (exp_acc && words_seen == 1) begin
      assert (word_got == exp_word) else report_mismatch("payload_word", id, word_got, exp_word);
    end
    assert (good_count == exp_good) else report_mismatch("good_count", id, good_count, exp_good);
  endtask

  initial begin : main_seq
    int idle;
    int gap;
    int errs_before;
    crsdv   = 1'b0;
    rxd     = 2'b00;
    sys_rst = 1'b1;
    seed    = 32'he338_2146;
    $readmemh("tests/eth_rx_vectors.hex", vec_mem);
    repeat (8) @(posedge clk_50mhz);
    #2;
    sys_rst = 1'b0;

    // test 0 covers idle outputs and a preamble with no delimiter
    errs_before = errors;
    words_seen  = 0;
    dones_seen  = 0;
    @(negedge clk_50mhz);
    assert (!word_valid && !accept && !frame_done && !frame_ok && good_count == '0) else begin
      $display("ERROR at %0t: outputs are not idle after reset", $time);
      errors++;
    end
    repeat (16) begin
      @(posedge clk_50mhz);
      #2;
      crsdv = 1'b1;
      rxd   = 2'b01;
    end
    @(posedge clk_50mhz);
    #2;
    crsdv = 1'b0;
    rxd   = 2'b00;
    repeat (8) @(posedge clk_50mhz);
    #5;
    assert (dones_seen == 0) else begin
      $display("ERROR at %0t: frame_done after a preamble with no delimiter", $time);
      errors++;
    end
    report_test(0, errs_before);

    for (int r = 0; r < NUM_REC; r++) begin
      errs_before = errors;
      send_frame(r * REC_BYTES, idle);
      check_frame(r * REC_BYTES);
      report_test(vec_mem[r*REC_BYTES], errs_before);
      // interframe gap counted from the carrier drop
      gap = 12 + ({$random(seed)} % 8);
      if (gap > idle) begin
        repeat (gap - idle) @(posedge clk_50mhz);
      end
    end

    $display("%0d tests, %0d passed, %0d failed, %0d errors", NUM_REC + 1, passed,
             NUM_REC + 1 - passed, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule
